// File: run.sh
#!/bin/sh
# Build the GEMM tiler testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f vlog.f --top-module tb_gemm_tiler -o sim_gemm_tiler
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_gemm_tiler)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

// File: tb/tb_gemm_tiler.sv
// Testbench for the GEMM tiler with random jobs checked against a tiling model
// Covers reset state, latency, selection word, large sizes, busy starts and clear
`timescale 1ns/1ns
`include "tiler_consts.svh"

module tb_gemm_tiler;

  import gemm_cfg_pkg::*;
  import tile_plan_pkg::*;

  localparam int n_random    = 60;
  localparam int n_sweep     = 40;
  localparam int n_large     = 6;
  localparam int n_jobs      = n_random + n_sweep + n_large + 3;
  localparam int cycle_limit = n_jobs * 60 + 200;

  logic        clk_int = 1'b0;
  logic        rst_ni, clear_i, start_i;
  dim_t        m_size_i, k_size_i, n_size_i;
  gemm_op_e    op_i;
  gemm_fmt_e   fmt_i;
  logic        valid_o;
  dim_t        x_rows_iter_o, x_cols_iter_o, w_rows_iter_o, w_cols_iter_o;
  dim_t        x_slots_o, tot_stores_o;
  logic [31:0] lftovr_o, x_d1_stride_o, w_d0_stride_o;
  logic [31:0] tot_x_read_o, w_tot_len_o, z_tot_len_o;
  op_sel_t     op_sel_o;

  // Expected plan from the model
  dim_t        exp_x_rows_iter, exp_x_cols_iter, exp_w_rows_iter, exp_w_cols_iter;
  dim_t        exp_x_slots, exp_tot_stores;
  logic [31:0] exp_lftovr, exp_x_d1_stride, exp_w_d0_stride;
  logic [31:0] exp_tot_x_read, exp_w_tot_len, exp_z_tot_len;
  op_sel_t     exp_op_sel;

  logic [31:0] rng_state = 32'h973b_ccdf;
  int          n_checks = 0;
  int          n_errors = 0;
  int          cycle_cnt = 0;

  always #2 clk_int = ~clk_int;

  gemm_tiler i_gemm_tiler (
    .clk_int       (clk_int),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .start_i       (start_i),
    .m_size_i      (m_size_i),
    .k_size_i      (k_size_i),
    .n_size_i      (n_size_i),
    .op_i          (op_i),
    .fmt_i         (fmt_i),
    .valid_o       (valid_o),
    .x_rows_iter_o (x_rows_iter_o),
    .x_cols_iter_o (x_cols_iter_o),
    .w_rows_iter_o (w_rows_iter_o),
    .w_cols_iter_o (w_cols_iter_o),
    .lftovr_o      (lftovr_o),
    .x_slots_o     (x_slots_o),
    .x_d1_stride_o (x_d1_stride_o),
    .w_d0_stride_o (w_d0_stride_o),
    .op_sel_o      (op_sel_o),
    .tot_stores_o  (tot_stores_o),
    .tot_x_read_o  (tot_x_read_o),
    .w_tot_len_o   (w_tot_len_o),
    .z_tot_len_o   (z_tot_len_o)
  );

  // Hard stop if a job never completes
  always @(posedge clk_int) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run went past %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] rand_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Size from 1 to 400 that is an exact multiple of tile one time in four
  function automatic dim_t pick_size(input int unsigned tile);
    logic [31:0] r;
    r = rand_next();
    if (r[31:30] == 2'd0) begin
      return dim_t'(tile * (1 + (r[29:8] % (400 / tile))));
    end
    return dim_t'(1 + (r[29:8] % 400));
  endfunction

  function automatic op_sel_t expected_sel(input gemm_op_e op, input gemm_fmt_e fmt);
    op_sel_t     s;
    logic [10:0] row;
    fpu_fmt_e    f;
    // Row holds stage 1 operation and the rounding of both stages
    case (op)
      MATMUL:  row = {FPU_FMADD, RNE, RNE};
      GEMM:    row = {FPU_FMADD, RNE, RNE};
      ADDMAX:  row = {FPU_ADD, RNE, RTZ};
      ADDMIN:  row = {FPU_ADD, RNE, RNE};
      MULMAX:  row = {FPU_MUL, RNE, RTZ};
      MULMIN:  row = {FPU_MUL, RNE, RNE};
      MAXMIN:  row = {FPU_MINMAX, RTZ, RNE};
      default: row = {FPU_MINMAX, RNE, RTZ};
    endcase
    case (fmt)
      FLOAT16:    f = FPU_FP16;
      FLOAT8:     f = FPU_FP8;
      FLOAT16ALT: f = FPU_FP16ALT;
      FLOAT8ALT:  f = FPU_FP8ALT;
      default:    f = FPU_FLOAT32;
    endcase
    s            = '0;
    s.stage1_op  = fpu_op_e'(row[10:6]);
    s.stage1_rnd = rnd_mode_e'(row[5:3]);
    s.stage2_rnd = rnd_mode_e'(row[2:0]);
    s.stage2_op  = FPU_MINMAX;
    s.in_fmt     = f;
    s.comp_fmt   = f;
    s.gemm_sel   = (op != MATMUL);
    return s;
  endfunction

  task automatic model_plan(input dim_t m, input dim_t k, input dim_t n,
                            input gemm_op_e op, input gemm_fmt_e fmt);
    int unsigned row_t, col_t, gran, xrl, xcl, wrl, wcl;
    logic [31:0] tiles;
    row_t = `TILER_ARRAY_WIDTH;
    col_t = `TILER_ARRAY_HEIGHT * (`TILER_PIPE_REGS + 1);
    gran  = `TILER_ARRAY_HEIGHT;
    xrl   = m % row_t;
    xcl   = n % col_t;
    wcl   = k % col_t;
    wrl   = n % gran;
    exp_x_rows_iter = dim_t'((m + row_t - 1) / row_t);
    exp_x_cols_iter = dim_t'((n + col_t - 1) / col_t);
    exp_w_cols_iter = dim_t'((k + col_t - 1) / col_t);
    exp_w_rows_iter = dim_t'((n + gran - 1) / gran * gran);
    exp_lftovr      = {xrl[7:0], xcl[7:0], wrl[7:0], wcl[7:0]};
    exp_x_slots     = dim_t'((xcl + gran - 1) / gran * gran);
    exp_x_d1_stride = 32'(`TILER_ELEM_BYTES * n);
    exp_w_d0_stride = 32'(`TILER_ELEM_BYTES * k);
    tiles           = 32'(exp_x_rows_iter) * 32'(exp_w_cols_iter);
    exp_tot_stores  = tiles[15:0];
    exp_tot_x_read  = tiles * 32'(exp_x_cols_iter);
    exp_w_tot_len   = tiles * 32'(exp_w_rows_iter);
    exp_z_tot_len   = 32'(`TILER_ARRAY_WIDTH) * 32'(exp_tot_stores);
    exp_op_sel      = expected_sel(op, fmt);
  endtask

  task automatic clear_expected();
    exp_x_rows_iter = '0;
    exp_x_cols_iter = '0;
    exp_w_rows_iter = '0;
    exp_w_cols_iter = '0;
    exp_lftovr      = '0;
    exp_x_slots     = '0;
    exp_x_d1_stride = '0;
    exp_w_d0_stride = '0;
    exp_tot_stores  = '0;
    exp_tot_x_read  = '0;
    exp_w_tot_len   = '0;
    exp_z_tot_len   = '0;
    exp_op_sel      = '0;
  endtask

  task automatic note_failure(input string msg);
    n_checks++;
    n_errors++;
    $display("%s", msg);
  endtask

  task automatic check_dim(input string name, input dim_t exp_v, input dim_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("Error: %s expected 0x%h got 0x%h", name, exp_v, act_v);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("Error: %s expected 0x%h got 0x%h", name, exp_v, act_v);
    end
  endtask

  task automatic check_sel(input string name, input op_sel_t exp_v, input op_sel_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("Error: %s expected 0x%h got 0x%h", name, exp_v, act_v);
    end
  endtask

  task automatic check_plan();
    check_dim("x_rows_iter_o", exp_x_rows_iter, x_rows_iter_o);
    check_dim("x_cols_iter_o", exp_x_cols_iter, x_cols_iter_o);
    check_dim("w_rows_iter_o", exp_w_rows_iter, w_rows_iter_o);
    check_dim("w_cols_iter_o", exp_w_cols_iter, w_cols_iter_o);
    check_word("lftovr_o", exp_lftovr, lftovr_o);
    check_dim("x_slots_o", exp_x_slots, x_slots_o);
    check_word("x_d1_stride_o", exp_x_d1_stride, x_d1_stride_o);
    check_word("w_d0_stride_o", exp_w_d0_stride, w_d0_stride_o);
    check_sel("op_sel_o", exp_op_sel, op_sel_o);
    check_dim("tot_stores_o", exp_tot_stores, tot_stores_o);
    check_word("tot_x_read_o", exp_tot_x_read, tot_x_read_o);
    check_word("w_tot_len_o", exp_w_tot_len, w_tot_len_o);
    check_word("z_tot_len_o", exp_z_tot_len, z_tot_len_o);
  endtask

  // Pulse start for one edge and then scramble the inputs so only that edge counts
  task automatic drive_start(input dim_t m, input dim_t k, input dim_t n,
                             input gemm_op_e op, input gemm_fmt_e fmt);
    @(negedge clk_int);
    m_size_i = m;
    k_size_i = k;
    n_size_i = n;
    op_i     = op;
    fmt_i    = fmt;
    start_i  = 1'b1;
    @(posedge clk_int);
    @(negedge clk_int);
    start_i  = 1'b0;
    m_size_i = ~m;
    k_size_i = ~k;
    n_size_i = ~n;
    op_i     = gemm_op_e'(~op);
    fmt_i    = gemm_fmt_e'(~fmt);
  endtask

  // Runs one job with an extra start pulse at edge poke_at when that is nonzero
  task automatic run_job(input dim_t m, input dim_t k, input dim_t n,
                         input gemm_op_e op, input gemm_fmt_e fmt, input int poke_at);
    int lat;
    model_plan(m, k, n, op, fmt);
    drive_start(m, k, n, op, fmt);
    lat = 0;
    // Old valid_o may still be up for the first two edges
    while (lat < 60 && !(lat >= 2 && valid_o)) begin
      if (lat + 1 == poke_at) begin
        start_i = 1'b1;
      end
      @(posedge clk_int);
      @(negedge clk_int);
      start_i = 1'b0;
      lat++;
    end
    if (!(valid_o && lat >= 2)) begin
      note_failure("valid_o did not rise within 60 cycles of start");
    end else if (lat != 52) begin
      note_failure($sformatf("valid_o rose %0d cycles after start instead of 52", lat));
    end
    check_plan();
  endtask

  task automatic abort_job(input dim_t m, input dim_t k, input dim_t n, input int clear_at);
    logic seen;
    seen = 1'b0;
    drive_start(m, k, n, GEMM, FLOAT16);
    repeat (clear_at - 1) begin
      @(posedge clk_int);
      @(negedge clk_int);
    end
    clear_i = 1'b1;
    @(posedge clk_int);
    @(negedge clk_int);
    clear_i = 1'b0;
    clear_expected();
    check_plan();
    repeat (56) begin
      @(posedge clk_int);
      @(negedge clk_int);
      seen = seen | (valid_o !== 1'b0);
    end
    if (seen) begin
      note_failure("valid_o went high after the job was cleared");
    end
    check_plan();
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    if (n_errors == errs_at_start) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: fail with %0d errors", name, n_errors - errs_at_start);
    end
  endtask

  initial begin
    logic [31:0] r;
    int          errs;
    rst_ni   = 1'b0;
    clear_i  = 1'b0;
    start_i  = 1'b0;
    m_size_i = '0;
    k_size_i = '0;
    n_size_i = '0;
    op_i     = MATMUL;
    fmt_i    = FLOAT32;
    repeat (16) @(posedge clk_int);
    @(negedge clk_int);
    rst_ni = 1'b1;

    errs = n_errors;
    @(negedge clk_int);
    if (valid_o !== 1'b0) begin
      note_failure($sformatf("Error: valid_o expected 0x0 got 0x%h", valid_o));
    end
    clear_expected();
    check_plan();
    end_test("reset state", errs);

    errs = n_errors;
    for (int i = 0; i < n_random; i++) begin
      r = rand_next();
      run_job(pick_size(12), pick_size(16), pick_size((i % 2 == 1) ? 4 : 16),
              gemm_op_e'(r[18:16]), gemm_fmt_e'(r[26:24] % 3'd5), 0);
    end
    end_test("random jobs", errs);

    errs = n_errors;
    for (int o = 0; o < 8; o++) begin
      for (int f = 0; f < 5; f++) begin
        run_job(pick_size(12), pick_size(16), pick_size(16),
                gemm_op_e'(o[2:0]), gemm_fmt_e'(f[2:0]), 0);
      end
    end
    end_test("operation and format sweep", errs);

    errs = n_errors;
    run_job(16'hffff, 16'hffff, 16'hffff, GEMM, FLOAT32, 0);
    run_job(16'hfffc, 16'hfff0, 16'hfff0, MULMAX, FLOAT8, 0);
    run_job(16'hea60, 16'hffef, 16'hfffd, ADDMIN, FLOAT16ALT, 0);
    for (int i = 0; i < n_large - 3; i++) begin
      r = rand_next();
      run_job(16'hf000 | r[27:16], 16'hf000 | r[19:8], 16'hf000 | r[11:0],
              MATMUL, FLOAT8ALT, 0);
    end
    end_test("large sizes", errs);

    errs = n_errors;
    run_job(16'd100, 16'd200, 16'd37, MAXMIN, FLOAT16, 30);
    abort_job(16'd250, 16'd90, 16'd61, 20);
    run_job(16'd47, 16'd33, 16'd130, ADDMAX, FLOAT8, 0);
    end_test("busy start and clear", errs);

    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/gemm_cfg_pkg.sv
// Types for the job that software writes into the tiler
// Sizes, the requested operation and the element format
`include "tiler_consts.svh"

package gemm_cfg_pkg;

  // Matrix size or iteration count
  typedef logic [`TILER_DIM_W-1:0] dim_t;

  // Operation codes, code 7 is reserved
  typedef enum logic [2:0] {
    MATMUL = 3'd0,
    GEMM   = 3'd1,
    ADDMAX = 3'd2,
    ADDMIN = 3'd3,
    MULMAX = 3'd4,
    MULMIN = 3'd5,
    MAXMIN = 3'd6
  } gemm_op_e;

  // Element formats as seen by software
  typedef enum logic [2:0] {
    FLOAT32    = 3'd0,
    FLOAT16    = 3'd1,
    FLOAT8     = 3'd2,
    FLOAT16ALT = 3'd3,
    FLOAT8ALT  = 3'd4
  } gemm_fmt_e;

endpackage

// File: verilog/gemm_tiler.sv
// Top of the GEMM tiler, decode, count and pack in a row
// Accepts a job on start_i and raises valid_o 52 cycles later
`timescale 1ns/1ns

module gemm_tiler (
  input  logic                    clk_int,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    start_i,
  input  gemm_cfg_pkg::dim_t      m_size_i,
  input  gemm_cfg_pkg::dim_t      k_size_i,
  input  gemm_cfg_pkg::dim_t      n_size_i,
  input  gemm_cfg_pkg::gemm_op_e  op_i,
  input  gemm_cfg_pkg::gemm_fmt_e fmt_i,
  output logic                    valid_o,
  output gemm_cfg_pkg::dim_t      x_rows_iter_o,
  output gemm_cfg_pkg::dim_t      x_cols_iter_o,
  output gemm_cfg_pkg::dim_t      w_rows_iter_o,
  output gemm_cfg_pkg::dim_t      w_cols_iter_o,
  output logic [31:0]             lftovr_o,
  output gemm_cfg_pkg::dim_t      x_slots_o,
  output logic [31:0]             x_d1_stride_o,
  output logic [31:0]             w_d0_stride_o,
  output tile_plan_pkg::op_sel_t  op_sel_o,
  output gemm_cfg_pkg::dim_t      tot_stores_o,
  output logic [31:0]             tot_x_read_o,
  output logic [31:0]             w_tot_len_o,
  output logic [31:0]             z_tot_len_o
);

  import gemm_cfg_pkg::*;
  import tile_plan_pkg::*;

  logic        dec_valid, cnt_valid;
  dim_t        dec_x_rows_iter, dec_x_cols_iter, dec_w_rows_iter, dec_w_cols_iter;
  dim_t        dec_x_slots, cnt_tot_stores;
  logic [31:0] dec_lftovr, dec_x_d1_stride, dec_w_d0_stride;
  logic [31:0] cnt_tot_x_read, cnt_w_tot_len;
  op_sel_t     dec_op_sel;

  // cnt_valid closes the busy window in decode
  tiler_decode i_decode (
    .clk_int       (clk_int),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .start_i       (start_i),
    .m_size_i      (m_size_i),
    .k_size_i      (k_size_i),
    .n_size_i      (n_size_i),
    .op_i          (op_i),
    .fmt_i         (fmt_i),
    .done_i        (cnt_valid),
    .dec_valid_o   (dec_valid),
    .x_rows_iter_o (dec_x_rows_iter),
    .x_cols_iter_o (dec_x_cols_iter),
    .w_rows_iter_o (dec_w_rows_iter),
    .w_cols_iter_o (dec_w_cols_iter),
    .lftovr_o      (dec_lftovr),
    .x_slots_o     (dec_x_slots),
    .x_d1_stride_o (dec_x_d1_stride),
    .w_d0_stride_o (dec_w_d0_stride),
    .op_sel_o      (dec_op_sel)
  );

  tiler_count i_count (
    .clk_int       (clk_int),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .dec_valid_i   (dec_valid),
    .x_rows_iter_i (dec_x_rows_iter),
    .x_cols_iter_i (dec_x_cols_iter),
    .w_rows_iter_i (dec_w_rows_iter),
    .w_cols_iter_i (dec_w_cols_iter),
    .cnt_valid_o   (cnt_valid),
    .tot_stores_o  (cnt_tot_stores),
    .tot_x_read_o  (cnt_tot_x_read),
    .w_tot_len_o   (cnt_w_tot_len)
  );

  tiler_pack i_pack (
    .clk_int       (clk_int),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .dec_valid_i   (dec_valid),
    .cnt_valid_i   (cnt_valid),
    .x_rows_iter_i (dec_x_rows_iter),
    .x_cols_iter_i (dec_x_cols_iter),
    .w_rows_iter_i (dec_w_rows_iter),
    .w_cols_iter_i (dec_w_cols_iter),
    .lftovr_i      (dec_lftovr),
    .x_slots_i     (dec_x_slots),
    .x_d1_stride_i (dec_x_d1_stride),
    .w_d0_stride_i (dec_w_d0_stride),
    .op_sel_i      (dec_op_sel),
    .tot_stores_i  (cnt_tot_stores),
    .tot_x_read_i  (cnt_tot_x_read),
    .w_tot_len_i   (cnt_w_tot_len),
    .valid_o       (valid_o),
    .x_rows_iter_o (x_rows_iter_o),
    .x_cols_iter_o (x_cols_iter_o),
    .w_rows_iter_o (w_rows_iter_o),
    .w_cols_iter_o (w_cols_iter_o),
    .lftovr_o      (lftovr_o),
    .x_slots_o     (x_slots_o),
    .x_d1_stride_o (x_d1_stride_o),
    .w_d0_stride_o (w_d0_stride_o),
    .op_sel_o      (op_sel_o),
    .tot_stores_o  (tot_stores_o),
    .tot_x_read_o  (tot_x_read_o),
    .w_tot_len_o   (w_tot_len_o),
    .z_tot_len_o   (z_tot_len_o)
  );

endmodule

// File: verilog/tile_plan_pkg.sv
// Types for the plan handed to the array controller
// Encodings follow the FPU of the two floating-point stages
package tile_plan_pkg;

  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001
  } rnd_mode_e;

  typedef enum logic [4:0] {
    FPU_FMADD  = 5'd0,
    FPU_ADD    = 5'd2,
    FPU_MUL    = 5'd3,
    FPU_MINMAX = 5'd7
  } fpu_op_e;

  typedef enum logic [2:0] {
    FPU_FLOAT32 = 3'd0,
    FPU_FP16    = 3'd2,
    FPU_FP8     = 3'd3,
    FPU_FP16ALT = 3'd4,
    FPU_FP8ALT  = 3'd5
  } fpu_fmt_e;

  // Selection word, MSB first
  typedef struct packed {
    rnd_mode_e  stage1_rnd;
    rnd_mode_e  stage2_rnd;
    fpu_op_e    stage1_op;
    fpu_op_e    stage2_op;
    fpu_fmt_e   in_fmt;
    fpu_fmt_e   comp_fmt;
    logic [8:0] spare;
    logic       gemm_sel;
  } op_sel_t;

endpackage

// File: verilog/tiler_consts.svh
// Array geometry and width constants for the GEMM tiler
// Include this wherever tile sizes, element size or dimension widths are needed
`ifndef TILER_CONSTS_SVH
`define TILER_CONSTS_SVH

// Rows of the systolic array, sets the X row tile
`define TILER_ARRAY_WIDTH 12

// Columns of the array, sets the W row and X slot granularity
`define TILER_ARRAY_HEIGHT 4

// Pipeline registers inside each processing element
`define TILER_PIPE_REGS 3

// Bytes per stored element
`define TILER_ELEM_BYTES 2

// Width of one matrix dimension, also the narrow multiplier operand
`define TILER_DIM_W 16

`endif

// File: verilog/tiler_count.sv
// Second tiler stage, derives the job totals from the iteration counts
// A 16x16 product feeds two parallel 16x32 products that finish together
`timescale 1ns/1ns
`include "tiler_consts.svh"

module tiler_count (
  input  logic               clk_int,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic               dec_valid_i,
  input  gemm_cfg_pkg::dim_t x_rows_iter_i,
  input  gemm_cfg_pkg::dim_t x_cols_iter_i,
  input  gemm_cfg_pkg::dim_t w_rows_iter_i,
  input  gemm_cfg_pkg::dim_t w_cols_iter_i,
  output logic               cnt_valid_o,
  output gemm_cfg_pkg::dim_t tot_stores_o,
  output logic [31:0]        tot_x_read_o,
  output logic [31:0]        w_tot_len_o
);

  localparam int unsigned dim_w = `TILER_DIM_W;
  localparam int unsigned tot_w = 32;

  logic                   tiles_done, xr_done, wl_done;
  logic [2*dim_w-1:0]     tiles_prod;
  logic [dim_w+tot_w-1:0] xr_prod, wl_prod;

  // Output tiles, x_rows_iter * w_cols_iter
  tiler_seq_mult #(.AW(dim_w), .BW(dim_w)) i_tiles_mult (
    .clk_int (clk_int),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .start_i (dec_valid_i),
    .a_i     (x_rows_iter_i),
    .b_i     (w_cols_iter_i),
    .done_o  (tiles_done),
    .prod_o  (tiles_prod)
  );

  // X reads, one per tile and X column step
  tiler_seq_mult #(.AW(dim_w), .BW(tot_w)) i_x_read_mult (
    .clk_int (clk_int),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .start_i (tiles_done),
    .a_i     (x_cols_iter_i),
    .b_i     (tiles_prod),
    .done_o  (xr_done),
    .prod_o  (xr_prod)
  );

  // W words, one per tile and W row
  tiler_seq_mult #(.AW(dim_w), .BW(tot_w)) i_w_len_mult (
    .clk_int (clk_int),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .start_i (tiles_done),
    .a_i     (w_rows_iter_i),
    .b_i     (tiles_prod),
    .done_o  (wl_done),
    .prod_o  (wl_prod)
  );

  assign tot_stores_o = tiles_prod[dim_w-1:0];
  assign tot_x_read_o = xr_prod[tot_w-1:0];
  assign w_tot_len_o  = wl_prod[tot_w-1:0];
  assign cnt_valid_o  = xr_done && wl_done;

  a_pair_in_step : assert property (@(posedge clk_int) disable iff (!rst_ni)
    xr_done == wl_done);

endmodule

// File: verilog/tiler_decode.sv
// First tiler stage, captures a job and decodes its tiling
// Iteration counts, leftovers, slots, strides and the FPU selection word
// Owns the busy level, a start while busy is dropped
`timescale 1ns/1ns
`include "tiler_consts.svh"

module tiler_decode (
  input  logic                    clk_int,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    start_i,
  input  gemm_cfg_pkg::dim_t      m_size_i,
  input  gemm_cfg_pkg::dim_t      k_size_i,
  input  gemm_cfg_pkg::dim_t      n_size_i,
  input  gemm_cfg_pkg::gemm_op_e  op_i,
  input  gemm_cfg_pkg::gemm_fmt_e fmt_i,
  input  logic                    done_i,
  output logic                    dec_valid_o,
  output gemm_cfg_pkg::dim_t      x_rows_iter_o,
  output gemm_cfg_pkg::dim_t      x_cols_iter_o,
  output gemm_cfg_pkg::dim_t      w_rows_iter_o,
  output gemm_cfg_pkg::dim_t      w_cols_iter_o,
  output logic [31:0]             lftovr_o,
  output gemm_cfg_pkg::dim_t      x_slots_o,
  output logic [31:0]             x_d1_stride_o,
  output logic [31:0]             w_d0_stride_o,
  output tile_plan_pkg::op_sel_t  op_sel_o
);

  import gemm_cfg_pkg::*;
  import tile_plan_pkg::*;

  localparam dim_t tile_rows = dim_t'(`TILER_ARRAY_WIDTH);
  localparam dim_t tile_cols = dim_t'(`TILER_ARRAY_HEIGHT * (`TILER_PIPE_REGS + 1));
  localparam dim_t col_gran  = dim_t'(`TILER_ARRAY_HEIGHT);
  localparam logic [31:0] elem_bytes = 32'(`TILER_ELEM_BYTES);

  dim_t     x_rows_lft, x_cols_lft, w_rows_lft, w_cols_lft;
  dim_t     x_slots_d;
  fpu_fmt_e fpu_fmt;
  op_sel_t  op_sel_d;
  logic     busy_q, launch_q, accept;

  assign x_rows_lft = m_size_i % tile_rows;
  assign x_cols_lft = n_size_i % tile_cols;
  assign w_cols_lft = k_size_i % tile_cols;
  assign w_rows_lft = n_size_i % col_gran;

  // Partial X column tile rounded up to whole array columns
  assign x_slots_d = ((x_cols_lft + col_gran - 1'b1) / col_gran) * col_gran;

  always_comb begin
    case (fmt_i)
      FLOAT16:    fpu_fmt = FPU_FP16;
      FLOAT8:     fpu_fmt = FPU_FP8;
      FLOAT16ALT: fpu_fmt = FPU_FP16ALT;
      FLOAT8ALT:  fpu_fmt = FPU_FP8ALT;
      default:    fpu_fmt = FPU_FLOAT32;
    endcase
  end

  always_comb begin
    op_sel_d            = '0;
    op_sel_d.stage2_op  = FPU_MINMAX;
    op_sel_d.in_fmt     = fpu_fmt;
    op_sel_d.comp_fmt   = fpu_fmt;
    op_sel_d.gemm_sel   = (op_i != MATMUL);
    op_sel_d.stage1_rnd = (op_i == MAXMIN) ? RTZ : RNE;
    // The max stages and the reserved code truncate in stage 2
    op_sel_d.stage2_rnd = (op_i inside {MATMUL, GEMM, ADDMIN, MULMIN, MAXMIN}) ? RNE : RTZ;
    case (op_i)
      MATMUL, GEMM:   op_sel_d.stage1_op = FPU_FMADD;
      ADDMAX, ADDMIN: op_sel_d.stage1_op = FPU_ADD;
      MULMAX, MULMIN: op_sel_d.stage1_op = FPU_MUL;
      default:        op_sel_d.stage1_op = FPU_MINMAX;
    endcase
  end

  assign accept = start_i && !busy_q && !clear_i;

  // Count stage is launched the cycle after the job is captured
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      launch_q    <= 1'b0;
      dec_valid_o <= 1'b0;
    end else if (clear_i) begin
      busy_q      <= 1'b0;
      launch_q    <= 1'b0;
      dec_valid_o <= 1'b0;
    end else begin
      launch_q    <= accept;
      dec_valid_o <= launch_q;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_int) begin
    if (accept) begin
      x_rows_iter_o <= m_size_i / tile_rows + dim_t'(x_rows_lft != '0);
      x_cols_iter_o <= n_size_i / tile_cols + dim_t'(x_cols_lft != '0);
      w_cols_iter_o <= k_size_i / tile_cols + dim_t'(w_cols_lft != '0);
      w_rows_iter_o <= (w_rows_lft != '0) ? n_size_i + col_gran - w_rows_lft : n_size_i;
      lftovr_o      <= {x_rows_lft[7:0], x_cols_lft[7:0], w_rows_lft[7:0], w_cols_lft[7:0]};
      x_slots_o     <= x_slots_d;
      x_d1_stride_o <= elem_bytes * 32'(n_size_i);
      w_d0_stride_o <= elem_bytes * 32'(k_size_i);
      op_sel_o      <= op_sel_d;
    end
  end

  a_dec_valid_pulse : assert property (@(posedge clk_int) disable iff (!rst_ni)
    dec_valid_o |=> !dec_valid_o);

endmodule

// File: verilog/tiler_pack.sv
// Third tiler stage, holds the finished plan for the array controller
// All fields update together on cnt_valid_i, valid_o stays up until cleared
`timescale 1ns/1ns
`include "tiler_consts.svh"

module tiler_pack (
  input  logic                   clk_int,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   dec_valid_i,
  input  logic                   cnt_valid_i,
  input  gemm_cfg_pkg::dim_t     x_rows_iter_i,
  input  gemm_cfg_pkg::dim_t     x_cols_iter_i,
  input  gemm_cfg_pkg::dim_t     w_rows_iter_i,
  input  gemm_cfg_pkg::dim_t     w_cols_iter_i,
  input  logic [31:0]            lftovr_i,
  input  gemm_cfg_pkg::dim_t     x_slots_i,
  input  logic [31:0]            x_d1_stride_i,
  input  logic [31:0]            w_d0_stride_i,
  input  tile_plan_pkg::op_sel_t op_sel_i,
  input  gemm_cfg_pkg::dim_t     tot_stores_i,
  input  logic [31:0]            tot_x_read_i,
  input  logic [31:0]            w_tot_len_i,
  output logic                   valid_o,
  output gemm_cfg_pkg::dim_t     x_rows_iter_o,
  output gemm_cfg_pkg::dim_t     x_cols_iter_o,
  output gemm_cfg_pkg::dim_t     w_rows_iter_o,
  output gemm_cfg_pkg::dim_t     w_cols_iter_o,
  output logic [31:0]            lftovr_o,
  output gemm_cfg_pkg::dim_t     x_slots_o,
  output logic [31:0]            x_d1_stride_o,
  output logic [31:0]            w_d0_stride_o,
  output tile_plan_pkg::op_sel_t op_sel_o,
  output gemm_cfg_pkg::dim_t     tot_stores_o,
  output logic [31:0]            tot_x_read_o,
  output logic [31:0]            w_tot_len_o,
  output logic [31:0]            z_tot_len_o
);

  localparam logic [31:0] tile_rows = 32'(`TILER_ARRAY_WIDTH);

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni || clear_i) begin
      valid_o       <= 1'b0;
      x_rows_iter_o <= '0;
      x_cols_iter_o <= '0;
      w_rows_iter_o <= '0;
      w_cols_iter_o <= '0;
      lftovr_o      <= '0;
      x_slots_o     <= '0;
      x_d1_stride_o <= '0;
      w_d0_stride_o <= '0;
      op_sel_o      <= '0;
      tot_stores_o  <= '0;
      tot_x_read_o  <= '0;
      w_tot_len_o   <= '0;
      z_tot_len_o   <= '0;
    end else if (cnt_valid_i) begin
      valid_o       <= 1'b1;
      x_rows_iter_o <= x_rows_iter_i;
      x_cols_iter_o <= x_cols_iter_i;
      w_rows_iter_o <= w_rows_iter_i;
      w_cols_iter_o <= w_cols_iter_i;
      lftovr_o      <= lftovr_i;
      x_slots_o     <= x_slots_i;
      x_d1_stride_o <= x_d1_stride_i;
      w_d0_stride_o <= w_d0_stride_i;
      op_sel_o      <= op_sel_i;
      tot_stores_o  <= tot_stores_i;
      tot_x_read_o  <= tot_x_read_i;
      w_tot_len_o   <= w_tot_len_i;
      // Z rows written, one array-width block per store
      z_tot_len_o   <= tile_rows * 32'(tot_stores_i);
    end else if (dec_valid_i) begin
      // Old plan is stale once a new job is launched
      valid_o <= 1'b0;
    end
  end

endmodule

// File: verilog/tiler_seq_mult.sv
// Sequential shift-add multiplier, one bit of B per cycle
// Pulse start_i with stable operands, done_o pulses BW+1 cycles later
`timescale 1ns/1ns

module tiler_seq_mult #(
  parameter int unsigned AW = 16,
  parameter int unsigned BW = 16
) (
  input  logic             clk_int,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             start_i,
  input  logic [AW-1:0]    a_i,
  input  logic [BW-1:0]    b_i,
  output logic             done_o,
  output logic [AW+BW-1:0] prod_o
);

  localparam int unsigned cnt_w = $clog2(BW);

  logic             running_q;
  logic [cnt_w-1:0] step_q;
  logic             last_step;
  logic             load;
  logic [AW+BW-1:0] a_sh_q;
  logic [AW+BW-1:0] acc_q;
  logic [BW-1:0]    b_sh_q;

  assign load      = start_i && !running_q && !clear_i;
  assign last_step = (step_q == cnt_w'(BW - 1));

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= 1'b0;
      step_q    <= '0;
      done_o    <= 1'b0;
    end else if (clear_i) begin
      running_q <= 1'b0;
      step_q    <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= running_q && last_step;
      if (load) begin
        running_q <= 1'b1;
        step_q    <= '0;
      end else if (running_q) begin
        step_q <= step_q + 1'b1;
        if (last_step) begin
          running_q <= 1'b0;
        end
      end
    end
  end

  // Accumulate A shifted by the current bit position of B
  always_ff @(posedge clk_int) begin
    if (load) begin
      a_sh_q <= {{BW{1'b0}}, a_i};
      b_sh_q <= b_i;
      acc_q  <= '0;
    end else if (running_q) begin
      if (b_sh_q[0]) begin
        acc_q <= acc_q + a_sh_q;
      end
      a_sh_q <= a_sh_q << 1;
      b_sh_q <= b_sh_q >> 1;
    end
  end

  assign prod_o = acc_q;

  a_done_single : assert property (@(posedge clk_int) disable iff (!rst_ni)
    done_o |=> !done_o);

  // Upstream must wait for done before launching the next product
  a_no_restart : assert property (@(posedge clk_int) disable iff (!rst_ni || clear_i)
    start_i |-> !running_q);

endmodule

// File: vlog.f
+incdir+verilog
verilog/gemm_cfg_pkg.sv
verilog/tile_plan_pkg.sv
verilog/tiler_seq_mult.sv
verilog/tiler_decode.sv
verilog/tiler_count.sv
verilog/tiler_pack.sv
verilog/gemm_tiler.sv
tb/tb_gemm_tiler.sv
